//--- mem_subsys.f
design/mem_subsys_pkg.sv
design/mem_stage.sv
design/mem_access.sv
design/inst_fetch.sv
design/mem_arbiter.sv
design/sys_ram.sv
design/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  # package first, then the blocks, then the top level
  - design/mem_subsys_pkg.sv
  - design/mem_stage.sv
  - design/mem_access.sv
  - design/inst_fetch.sv
  - design/mem_arbiter.sv
  - design/sys_ram.sv
  - design/mem_subsys_top.sv

  - target: test
    files:
      - verif/tb_mem_subsys.sv

//--- verif/tb_mem_subsys.sv
/* memory subsystem testbench
   directed stage, RAM and fetch tests against a byte-level shadow model */
`timescale 1ns/1ns

module tb_mem_subsys;

  localparam int XL = mem_subsys_pkg::XLEN;
  localparam int IL = mem_subsys_pkg::ILEN;
  localparam int RW = mem_subsys_pkg::RIDX_W;
  localparam int TIMEOUT = 64;

  logic clk, rst;
  logic i_executed_req, o_executed_ack, o_memoryed_req, i_memoryed_ack;
  mem_subsys_pkg::mem_op_e i_op;
  logic [XL-1:0] i_pc, i_op1, i_op2, i_op3, i_rd_wdata, o_pc, o_rd_wdata, i_fetch_pc;
  logic [IL-1:0] i_inst, o_inst, o_fetch_inst;
  logic [RW-1:0] i_rd, o_rd;
  logic i_rd_wen, o_rd_wen, i_fetch_req, o_fetch_busy, o_fetch_valid;

  // byte image of the RAM, indexed by addr[11:0]
  logic [7:0]    shadow [4096];
  logic [63:0]   lcg_state;
  logic [XL-1:0] pc_ctr;
  int mismatches, timeouts;

  mem_subsys_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [63:0] lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state;
  endfunction

  // word-aligned address somewhere in the 4 KiB window
  function automatic logic [XL-1:0] random_base();
    logic [63:0] r;
    r = lcg_next();
    return 64'h8000_0000 | {52'h0, r[43:35], 3'b000};
  endfunction

  function automatic int size_of(input mem_subsys_pkg::mem_op_e op);
    case (op)
      mem_subsys_pkg::OP_LB, mem_subsys_pkg::OP_LBU, mem_subsys_pkg::OP_SB: return 1;
      mem_subsys_pkg::OP_LH, mem_subsys_pkg::OP_LHU, mem_subsys_pkg::OP_SH: return 2;
      mem_subsys_pkg::OP_LW, mem_subsys_pkg::OP_LWU, mem_subsys_pkg::OP_SW: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic is_load_op(input mem_subsys_pkg::mem_op_e op);
    return op inside {mem_subsys_pkg::OP_LB, mem_subsys_pkg::OP_LBU, mem_subsys_pkg::OP_LH,
                      mem_subsys_pkg::OP_LHU, mem_subsys_pkg::OP_LW, mem_subsys_pkg::OP_LWU,
                      mem_subsys_pkg::OP_LD};
  endfunction

  function automatic void shadow_store(input mem_subsys_pkg::mem_op_e op,
                                       input logic [XL-1:0] addr, input logic [XL-1:0] data);
    for (int i = 0; i < size_of(op); i++) shadow[addr[11:0] + 12'(i)] = data[8*i +: 8];
  endfunction

  // little-endian gather, then sign fill for LB, LH and LW
  function automatic logic [XL-1:0] expected_load(input mem_subsys_pkg::mem_op_e op,
                                                  input logic [XL-1:0] addr);
    logic [XL-1:0] v;
    int n;
    n = size_of(op);
    v = '0;
    for (int i = 0; i < n; i++) v[8*i +: 8] = shadow[addr[11:0] + 12'(i)];
    if (op inside {mem_subsys_pkg::OP_LB, mem_subsys_pkg::OP_LH, mem_subsys_pkg::OP_LW}
        && v[8*n-1])
      v = v | (~64'h0 << (8*n));
    return v;
  endfunction

  function automatic logic [IL-1:0] expected_inst(input logic [XL-1:0] pc);
    logic [11:0] a;
    a = {pc[11:2], 2'b00};
    return {shadow[a + 12'd3], shadow[a + 12'd2], shadow[a + 12'd1], shadow[a]};
  endfunction

  task automatic check_xlen(input string name, input logic [XL-1:0] got,
                            input logic [XL-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_inst(input string name, input logic [IL-1:0] got,
                            input logic [IL-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_ridx(input string name, input logic [RW-1:0] got,
                            input logic [RW-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  // returns on the falling edge right after the handshake edge
  task automatic issue_instr(input mem_subsys_pkg::mem_op_e op, input logic [XL-1:0] op1,
                             input logic [XL-1:0] op2, input logic [XL-1:0] op3,
                             input logic [RW-1:0] rd, input logic [XL-1:0] rd_wdata);
    logic [63:0] r;
    int n;
    r = lcg_next();
    n = 0;
    i_op = op;
    i_pc = pc_ctr;
    i_inst = r[IL-1:0];
    i_op1 = op1;
    i_op2 = op2;
    i_op3 = op3;
    i_rd = rd;
    i_rd_wen = (rd != '0);
    i_rd_wdata = rd_wdata;
    i_executed_req = 1'b1;
    while (!o_executed_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_executed_ack) begin
      $display("timeout: the stage never accepted the instruction");
      timeouts++;
    end
    @(negedge clk);
    i_executed_req = 1'b0;
    pc_ctr = pc_ctr + 64'd4;
  endtask

  task automatic collect_result();
    int n;
    n = 0;
    while (!o_memoryed_req && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_memoryed_req) begin
      $display("timeout: no result was offered to writeback");
      timeouts++;
    end
  endtask

  task automatic release_result();
    i_memoryed_ack = 1'b1;
    @(negedge clk);
    i_memoryed_ack = 1'b0;
  endtask

  task automatic catch_fetch_valid();
    int n;
    n = 0;
    while (!o_fetch_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_fetch_valid) begin
      $display("timeout: the fetch never returned an instruction");
      timeouts++;
    end
  endtask

  task automatic run_mem(input mem_subsys_pkg::mem_op_e op, input logic [XL-1:0] base,
                         input logic [XL-1:0] offset, input logic [XL-1:0] data);
    logic [XL-1:0] addr, exp;
    addr = base + offset;
    exp = expected_load(op, addr);
    issue_instr(op, base, data, offset, 5'd10, '0);
    collect_result();
    check_ridx("o_rd", o_rd, 5'd10);
    if (is_load_op(op))
      check_xlen("o_rd_wdata", o_rd_wdata, exp);
    else
      shadow_store(op, addr, data);
    release_result();
  endtask

  task automatic pass_through();
    logic [XL-1:0] r;
    r = lcg_next();
    issue_instr(mem_subsys_pkg::OP_NONE, r, ~r, r ^ 64'h55, 5'd7, r);
    check_flag("o_memoryed_req", o_memoryed_req, 1'b1);
    collect_result();
    check_xlen("o_pc", o_pc, i_pc);
    check_inst("o_inst", o_inst, i_inst);
    check_ridx("o_rd", o_rd, 5'd7);
    check_flag("o_rd_wen", o_rd_wen, 1'b1);
    check_xlen("o_rd_wdata", o_rd_wdata, r);
    release_result();
  endtask

  task automatic full_width_rw();
    logic [XL-1:0] base;
    base = random_base();
    run_mem(mem_subsys_pkg::OP_SD, base, 64'd16, lcg_next());
    run_mem(mem_subsys_pkg::OP_LD, base, 64'd16, '0);
    // negative offset
    run_mem(mem_subsys_pkg::OP_SD, base + 64'd64, 64'hffff_ffff_ffff_fff8, lcg_next());
    run_mem(mem_subsys_pkg::OP_LD, base + 64'd56, 64'd0, '0);
  endtask

  task automatic byte_half_lanes();
    logic [XL-1:0] base;
    base = random_base();
    run_mem(mem_subsys_pkg::OP_SD, base, 64'd0, lcg_next());
    run_mem(mem_subsys_pkg::OP_SB, base, 64'd3, lcg_next() | 64'h80);
    run_mem(mem_subsys_pkg::OP_SB, base, 64'd6, lcg_next() & ~64'h80);
    run_mem(mem_subsys_pkg::OP_SH, base, 64'd0, lcg_next() | 64'h8000);
    run_mem(mem_subsys_pkg::OP_LB, base, 64'd3, '0);
    run_mem(mem_subsys_pkg::OP_LBU, base, 64'd3, '0);
    run_mem(mem_subsys_pkg::OP_LB, base, 64'd6, '0);
    run_mem(mem_subsys_pkg::OP_LBU, base, 64'd6, '0);
    run_mem(mem_subsys_pkg::OP_LH, base, 64'd0, '0);
    run_mem(mem_subsys_pkg::OP_LHU, base, 64'd0, '0);
    run_mem(mem_subsys_pkg::OP_LH, base, 64'd4, '0);
  endtask

  task automatic word_extension();
    logic [XL-1:0] base;
    base = random_base();
    run_mem(mem_subsys_pkg::OP_SD, base, 64'd0, lcg_next());
    run_mem(mem_subsys_pkg::OP_SW, base, 64'd4, lcg_next() | 64'h8000_0000);
    run_mem(mem_subsys_pkg::OP_LW, base, 64'd4, '0);
    run_mem(mem_subsys_pkg::OP_LWU, base, 64'd4, '0);
  endtask

  task automatic back_pressure();
    logic [XL-1:0] base, held_data, held_pc;
    base = random_base();
    run_mem(mem_subsys_pkg::OP_SD, base, 64'd8, lcg_next() | 64'h8000_0000_0000_0000);
    issue_instr(mem_subsys_pkg::OP_LD, base, '0, 64'd8, 5'd11, '0);
    collect_result();
    held_data = o_rd_wdata;
    held_pc = o_pc;
    check_xlen("o_rd_wdata", held_data, expected_load(mem_subsys_pkg::OP_LD, base + 64'd8));
    repeat (6) begin
      @(negedge clk);
      check_flag("o_executed_ack", o_executed_ack, 1'b0);
      check_flag("o_memoryed_req", o_memoryed_req, 1'b1);
      check_xlen("o_rd_wdata", o_rd_wdata, held_data);
      check_xlen("o_pc", o_pc, held_pc);
    end
    release_result();
    check_flag("o_executed_ack", o_executed_ack, 1'b1);
  endtask

  // fetch strobe lands while the load owns the RAM
  task automatic shared_ram();
    logic [XL-1:0] base, ld_base;
    base = random_base();
    ld_base = base ^ 64'h400;
    run_mem(mem_subsys_pkg::OP_SW, base, 64'd4, lcg_next());
    run_mem(mem_subsys_pkg::OP_SD, ld_base, 64'd0, lcg_next());
    issue_instr(mem_subsys_pkg::OP_LD, ld_base, '0, '0, 5'd12, '0);
    i_fetch_req = 1'b1;
    i_fetch_pc = base + 64'd4;
    fork
      begin
        @(negedge clk);
        i_fetch_req = 1'b0;
        check_flag("o_fetch_busy", o_fetch_busy, 1'b1);
        catch_fetch_valid();
        check_inst("o_fetch_inst", o_fetch_inst, expected_inst(base + 64'd4));
        check_flag("o_fetch_busy", o_fetch_busy, 1'b0);
      end
      begin
        collect_result();
        check_xlen("o_rd_wdata", o_rd_wdata, expected_load(mem_subsys_pkg::OP_LD, ld_base));
        release_result();
      end
    join
  endtask

  initial begin
    lcg_state = 64'd43;
    pc_ctr = 64'h8000_1000;
    mismatches = 0;
    timeouts = 0;
    rst = 1'b1;
    i_executed_req = 1'b0;
    i_op = mem_subsys_pkg::OP_NONE;
    i_pc = '0;
    i_inst = '0;
    i_op1 = '0;
    i_op2 = '0;
    i_op3 = '0;
    i_rd = '0;
    i_rd_wen = 1'b0;
    i_rd_wdata = '0;
    i_memoryed_ack = 1'b0;
    i_fetch_req = 1'b0;
    i_fetch_pc = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("o_executed_ack", o_executed_ack, 1'b1);
    check_flag("o_memoryed_req", o_memoryed_req, 1'b0);
    check_flag("o_fetch_busy", o_fetch_busy, 1'b0);
    check_flag("o_fetch_valid", o_fetch_valid, 1'b0);
    pass_through();
    full_width_rw();
    byte_half_lanes();
    word_extension();
    back_pressure();
    shared_ram();
    $display("%0d value mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- design/mem_subsys_top.sv
/* memory subsystem top
   memory stage and fetch sharing one RAM through the arbiter */
`timescale 1ns/1ns

module mem_subsys_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_executed_req,
  output logic                              o_executed_ack,
  input  mem_subsys_pkg::mem_op_e           i_op,
  input  logic [mem_subsys_pkg::XLEN-1:0]   i_pc,
  input  logic [mem_subsys_pkg::ILEN-1:0]   i_inst,
  input  logic [mem_subsys_pkg::XLEN-1:0]   i_op1,
  input  logic [mem_subsys_pkg::XLEN-1:0]   i_op2,
  input  logic [mem_subsys_pkg::XLEN-1:0]   i_op3,
  input  logic [mem_subsys_pkg::RIDX_W-1:0] i_rd,
  input  logic                              i_rd_wen,
  input  logic [mem_subsys_pkg::XLEN-1:0]   i_rd_wdata,
  output logic                              o_memoryed_req,
  input  logic                              i_memoryed_ack,
  output logic [mem_subsys_pkg::XLEN-1:0]   o_pc,
  output logic [mem_subsys_pkg::ILEN-1:0]   o_inst,
  output logic [mem_subsys_pkg::RIDX_W-1:0] o_rd,
  output logic                              o_rd_wen,
  output logic [mem_subsys_pkg::XLEN-1:0]   o_rd_wdata,
  input  logic                              i_fetch_req,
  input  logic [mem_subsys_pkg::XLEN-1:0]   i_fetch_pc,
  output logic                              o_fetch_busy,
  output logic                              o_fetch_valid,
  output logic [mem_subsys_pkg::ILEN-1:0]   o_fetch_inst
);

  localparam int XL = mem_subsys_pkg::XLEN;

  // stage to access
  logic          acc_start, acc_we, acc_done;
  logic [7:0]    acc_be;
  logic [XL-1:0] acc_addr, acc_wdata, acc_rdata;

  // requesters to arbiter
  logic          d_req, d_we, d_ack, f_req, f_ack;
  logic [7:0]    d_be;
  logic [XL-1:0] d_addr, d_wdata, d_rdata, f_addr, f_rdata;

  // arbiter to RAM
  logic          ram_req, ram_we, ram_ack;
  logic [7:0]    ram_be;
  logic [XL-1:0] ram_addr, ram_wdata, ram_rdata;

  mem_stage u_mem_stage (
    .clk, .rst, .i_executed_req, .o_executed_ack, .i_op, .i_pc, .i_inst,
    .i_op1, .i_op2, .i_op3, .i_rd, .i_rd_wen, .i_rd_wdata,
    .o_memoryed_req, .i_memoryed_ack, .o_pc, .o_inst, .o_rd, .o_rd_wen, .o_rd_wdata,
    .o_acc_start(acc_start), .o_acc_addr(acc_addr), .o_acc_we(acc_we),
    .o_acc_be(acc_be), .o_acc_wdata(acc_wdata),
    .i_acc_done(acc_done), .i_acc_rdata(acc_rdata)
  );

  mem_access u_mem_access (
    .clk, .rst, .i_start(acc_start), .i_addr(acc_addr), .i_we(acc_we),
    .i_be(acc_be), .i_wdata(acc_wdata), .o_done(acc_done), .o_rdata(acc_rdata),
    .o_bus_req(d_req), .o_bus_addr(d_addr), .o_bus_we(d_we), .o_bus_be(d_be),
    .o_bus_wdata(d_wdata), .i_bus_ack(d_ack), .i_bus_rdata(d_rdata)
  );

  inst_fetch u_inst_fetch (
    .clk, .rst, .i_fetch_req, .i_fetch_pc, .o_fetch_busy, .o_fetch_valid, .o_fetch_inst,
    .o_bus_req(f_req), .o_bus_addr(f_addr), .i_bus_ack(f_ack), .i_bus_rdata(f_rdata)
  );

  mem_arbiter u_mem_arbiter (
    .clk, .rst,
    .i_d_req(d_req), .i_d_addr(d_addr), .i_d_we(d_we), .i_d_be(d_be),
    .i_d_wdata(d_wdata), .o_d_ack(d_ack), .o_d_rdata(d_rdata),
    .i_f_req(f_req), .i_f_addr(f_addr), .o_f_ack(f_ack), .o_f_rdata(f_rdata),
    .o_ram_req(ram_req), .o_ram_addr(ram_addr), .o_ram_we(ram_we), .o_ram_be(ram_be),
    .o_ram_wdata(ram_wdata), .i_ram_ack(ram_ack), .i_ram_rdata(ram_rdata)
  );

  sys_ram u_sys_ram (
    .clk, .rst, .i_req(ram_req), .i_addr(ram_addr), .i_we(ram_we), .i_be(ram_be),
    .i_wdata(ram_wdata), .o_ack(ram_ack), .o_rdata(ram_rdata)
  );

endmodule

//--- design/sys_ram.sv
/* single-port 64-bit RAM with byte enables
   acks every request one cycle after it is seen */
`timescale 1ns/1ns

module sys_ram (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_req,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_addr,
  input  logic                            i_we,
  input  logic [7:0]                      i_be,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_wdata,
  output logic                            o_ack,
  output logic [mem_subsys_pkg::XLEN-1:0] o_rdata
);

  logic [mem_subsys_pkg::XLEN-1:0] mem [mem_subsys_pkg::RAM_WORDS];

  logic [mem_subsys_pkg::RAM_AW-1:0] idx;
  logic                              take;

  assign idx  = i_addr[mem_subsys_pkg::RAM_AW+2:3];
  // request still high during its own ack cycle
  assign take = i_req & ~o_ack;

  always_ff @(posedge clk) begin
    if (rst) o_ack <= 1'b0;
    else     o_ack <= take;
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_rdata <= mem[idx];
      if (i_we) begin
        for (int b = 0; b < 8; b++) begin
          if (i_be[b]) mem[idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- design/mem_arbiter.sv
/* fixed-priority RAM arbiter
   data port wins, a grant is held until the RAM ack */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_d_req,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_d_addr,
  input  logic                            i_d_we,
  input  logic [7:0]                      i_d_be,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_d_wdata,
  output logic                            o_d_ack,
  output logic [mem_subsys_pkg::XLEN-1:0] o_d_rdata,
  input  logic                            i_f_req,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_f_addr,
  output logic                            o_f_ack,
  output logic [mem_subsys_pkg::XLEN-1:0] o_f_rdata,
  output logic                            o_ram_req,
  output logic [mem_subsys_pkg::XLEN-1:0] o_ram_addr,
  output logic                            o_ram_we,
  output logic [7:0]                      o_ram_be,
  output logic [mem_subsys_pkg::XLEN-1:0] o_ram_wdata,
  input  logic                            i_ram_ack,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_ram_rdata
);

  mem_subsys_pkg::arb_owner_e owner;
  mem_subsys_pkg::arb_owner_e grant;

  // a free RAM is granted in the same cycle as the request
  always_comb begin
    if (owner != mem_subsys_pkg::OWN_NONE) grant = owner;
    else if (i_d_req)                      grant = mem_subsys_pkg::OWN_DATA;
    else if (i_f_req)                      grant = mem_subsys_pkg::OWN_FETCH;
    else                                   grant = mem_subsys_pkg::OWN_NONE;
  end

  always_ff @(posedge clk) begin
    if (rst || i_ram_ack) owner <= mem_subsys_pkg::OWN_NONE;
    else                  owner <= grant;
  end

  assign o_ram_req   = (grant != mem_subsys_pkg::OWN_NONE);
  assign o_ram_addr  = (grant == mem_subsys_pkg::OWN_FETCH) ? i_f_addr : i_d_addr;
  assign o_ram_we    = (grant == mem_subsys_pkg::OWN_DATA) & i_d_we;
  assign o_ram_be    = i_d_be;
  assign o_ram_wdata = i_d_wdata;

  assign o_d_ack   = i_ram_ack & (owner == mem_subsys_pkg::OWN_DATA);
  assign o_f_ack   = i_ram_ack & (owner == mem_subsys_pkg::OWN_FETCH);
  assign o_d_rdata = (owner == mem_subsys_pkg::OWN_DATA) ? i_ram_rdata : '0;
  assign o_f_rdata = (owner == mem_subsys_pkg::OWN_FETCH) ? i_ram_rdata : '0;

  // an ack with no owner would reach neither port
  a_ack_owner : assert property (@(posedge clk) disable iff (rst)
    i_ram_ack |-> owner != mem_subsys_pkg::OWN_NONE);

endmodule

//--- design/inst_fetch.sv
/* instruction fetch requester
   reads one 32-bit instruction from the shared RAM per strobe */
`timescale 1ns/1ns

module inst_fetch (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_fetch_req,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_fetch_pc,
  output logic                            o_fetch_busy,
  output logic                            o_fetch_valid,
  output logic [mem_subsys_pkg::ILEN-1:0] o_fetch_inst,
  output logic                            o_bus_req,
  output logic [mem_subsys_pkg::XLEN-1:0] o_bus_addr,
  input  logic                            i_bus_ack,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_bus_rdata
);

  assign o_fetch_busy = o_bus_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req     <= 1'b0;
      o_fetch_valid <= 1'b0;
    end else begin
      o_fetch_valid <= o_bus_req & i_bus_ack;
      if (!o_bus_req && i_fetch_req) begin
        o_bus_req <= 1'b1;
      end else if (i_bus_ack) begin
        o_bus_req <= 1'b0;
      end
    end
  end

  // strobes while busy are dropped
  always_ff @(posedge clk) begin
    if (!o_bus_req && i_fetch_req) begin
      o_bus_addr <= i_fetch_pc;
    end
    if (o_bus_req && i_bus_ack) begin
      o_fetch_inst <= o_bus_addr[2] ? i_bus_rdata[63:32] : i_bus_rdata[31:0];
    end
  end

endmodule

//--- design/mem_access.sv
/* data-side bus requester
   holds one sized access on the bus until the RAM acknowledges it */
`timescale 1ns/1ns

module mem_access (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_start,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_addr,
  input  logic                            i_we,
  input  logic [7:0]                      i_be,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_wdata,
  output logic                            o_done,
  output logic [mem_subsys_pkg::XLEN-1:0] o_rdata,
  output logic                            o_bus_req,
  output logic [mem_subsys_pkg::XLEN-1:0] o_bus_addr,
  output logic                            o_bus_we,
  output logic [7:0]                      o_bus_be,
  output logic [mem_subsys_pkg::XLEN-1:0] o_bus_wdata,
  input  logic                            i_bus_ack,
  input  logic [mem_subsys_pkg::XLEN-1:0] i_bus_rdata
);

  logic [mem_subsys_pkg::XLEN-1:0] rdata_q;

  // done in the ack cycle so the stage can finish on the same edge
  assign o_done  = o_bus_req & i_bus_ack;
  assign o_rdata = o_done ? i_bus_rdata : rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req <= 1'b0;
    end else if (i_start) begin
      o_bus_req <= 1'b1;
    end else if (i_bus_ack) begin
      o_bus_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      o_bus_addr  <= i_addr;
      o_bus_we    <= i_we;
      o_bus_be    <= i_be;
      o_bus_wdata <= i_wdata;
    end
    if (o_done) begin
      rdata_q <= i_bus_rdata;
    end
  end

  a_no_overlap : assert property (@(posedge clk) disable iff (rst)
    i_start |-> !o_bus_req);

endmodule

//--- design/mem_stage.sv
/* memory stage: captures an executed instruction, issues its sized access
   and hands the extended result on to writeback */
`timescale 1ns/1ns

module mem_stage (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_executed_req,
  output logic                                o_executed_ack,
  input  mem_subsys_pkg::mem_op_e             i_op,
  input  logic [mem_subsys_pkg::XLEN-1:0]     i_pc,
  input  logic [mem_subsys_pkg::ILEN-1:0]     i_inst,
  input  logic [mem_subsys_pkg::XLEN-1:0]     i_op1,
  input  logic [mem_subsys_pkg::XLEN-1:0]     i_op2,
  input  logic [mem_subsys_pkg::XLEN-1:0]     i_op3,
  input  logic [mem_subsys_pkg::RIDX_W-1:0]   i_rd,
  input  logic                                i_rd_wen,
  input  logic [mem_subsys_pkg::XLEN-1:0]     i_rd_wdata,
  output logic                                o_memoryed_req,
  input  logic                                i_memoryed_ack,
  output logic [mem_subsys_pkg::XLEN-1:0]     o_pc,
  output logic [mem_subsys_pkg::ILEN-1:0]     o_inst,
  output logic [mem_subsys_pkg::RIDX_W-1:0]   o_rd,
  output logic                                o_rd_wen,
  output logic [mem_subsys_pkg::XLEN-1:0]     o_rd_wdata,
  output logic                                o_acc_start,
  output logic [mem_subsys_pkg::XLEN-1:0]     o_acc_addr,
  output logic                                o_acc_we,
  output logic [7:0]                          o_acc_be,
  output logic [mem_subsys_pkg::XLEN-1:0]     o_acc_wdata,
  input  logic                                i_acc_done,
  input  logic [mem_subsys_pkg::XLEN-1:0]     i_acc_rdata
);

  localparam int XL = mem_subsys_pkg::XLEN;

  mem_subsys_pkg::stage_state_e state;
  mem_subsys_pkg::mem_op_e      op_q;

  logic          exec_hs;
  logic          is_load;
  logic          is_store;
  logic [1:0]    size;
  logic [7:0]    be_base;
  logic [XL-1:0] eff_addr;
  logic [XL-1:0] lane;
  logic [XL-1:0] load_val;

  assign exec_hs = i_executed_req & o_executed_ack;
  assign o_executed_ack = (state == mem_subsys_pkg::IDLE);
  assign o_memoryed_req = (state == mem_subsys_pkg::HOLD);

  assign eff_addr = i_op1 + i_op3;
  assign is_load  = i_op inside {[mem_subsys_pkg::OP_LB:mem_subsys_pkg::OP_LD]};
  assign is_store = i_op inside {[mem_subsys_pkg::OP_SB:mem_subsys_pkg::OP_SD]};

  // log2 of the access size in bytes
  always_comb begin
    case (i_op)
      mem_subsys_pkg::OP_LH, mem_subsys_pkg::OP_LHU, mem_subsys_pkg::OP_SH: size = 2'd1;
      mem_subsys_pkg::OP_LW, mem_subsys_pkg::OP_LWU, mem_subsys_pkg::OP_SW: size = 2'd2;
      mem_subsys_pkg::OP_LD, mem_subsys_pkg::OP_SD: size = 2'd3;
      default: size = 2'd0;
    endcase
  end

  assign be_base = 8'hff >> (4'd8 - (4'd1 << size));

  // pull the addressed bytes down to lane 0, then extend
  always_comb begin
    lane = i_acc_rdata >> {o_acc_addr[2:0], 3'b000};
    case (op_q)
      mem_subsys_pkg::OP_LB:  load_val = {{(XL-8){lane[7]}}, lane[7:0]};
      mem_subsys_pkg::OP_LBU: load_val = {{(XL-8){1'b0}}, lane[7:0]};
      mem_subsys_pkg::OP_LH:  load_val = {{(XL-16){lane[15]}}, lane[15:0]};
      mem_subsys_pkg::OP_LHU: load_val = {{(XL-16){1'b0}}, lane[15:0]};
      mem_subsys_pkg::OP_LW:  load_val = {{(XL-32){lane[31]}}, lane[31:0]};
      mem_subsys_pkg::OP_LWU: load_val = {{(XL-32){1'b0}}, lane[31:0]};
      default:                load_val = lane;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_subsys_pkg::IDLE;
      o_acc_start <= 1'b0;
    end else begin
      o_acc_start <= exec_hs & (is_load | is_store);
      case (state)
        mem_subsys_pkg::IDLE:
          if (exec_hs) begin
            state <= (is_load | is_store) ? mem_subsys_pkg::ACCESS : mem_subsys_pkg::HOLD;
          end
        mem_subsys_pkg::ACCESS:
          if (i_acc_done) begin
            state <= mem_subsys_pkg::HOLD;
          end
        default:
          if (i_memoryed_ack) begin
            state <= mem_subsys_pkg::IDLE;
          end
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (exec_hs) begin
      op_q        <= i_op;
      o_pc        <= i_pc;
      o_inst      <= i_inst;
      o_rd        <= i_rd;
      o_rd_wen    <= i_rd_wen;
      o_rd_wdata  <= i_rd_wdata;
      o_acc_addr  <= eff_addr;
      o_acc_we    <= is_store;
      o_acc_be    <= be_base << eff_addr[2:0];
      o_acc_wdata <= i_op2 << {eff_addr[2:0], 3'b000};
    end else if (state == mem_subsys_pkg::ACCESS && i_acc_done && !o_acc_we) begin
      o_rd_wdata  <= load_val;
    end
  end

  a_aligned : assert property (@(posedge clk) disable iff (rst)
    exec_hs && (is_load || is_store) |-> (eff_addr[2:0] & ((3'd1 << size) - 3'd1)) == 3'd0);

endmodule

//--- design/mem_subsys_pkg.sv
/* memory subsystem package
   widths, RAM geometry and the shared enums */
package mem_subsys_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;
  localparam int RIDX_W = 5;

  // 4 KiB of 64-bit words, indexed by addr[11:3]
  localparam int RAM_WORDS = 512;
  localparam int RAM_AW = 9;

  // loads first, then stores; range checks rely on this order
  typedef enum logic [3:0] {
    OP_NONE,
    OP_LB,
    OP_LBU,
    OP_LH,
    OP_LHU,
    OP_LW,
    OP_LWU,
    OP_LD,
    OP_SB,
    OP_SH,
    OP_SW,
    OP_SD
  } mem_op_e;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    HOLD
  } stage_state_e;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_DATA,
    OWN_FETCH
  } arb_owner_e;

endpackage
